/* Makefile */
# Verilator build and run of the cluster testbench

BIN  := obj_dir/Vtb_mempool_cluster
SRCS := $(filter-out +%,$(shell cat all.f)) tests/cluster_model.svh

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(BIN): all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mempool_cluster \
	  -f all.f -o Vtb_mempool_cluster

run: $(BIN)
	./$(BIN) | tee sim.log

# the log decides pass or fail
check: run
	grep -q '^TEST OK$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
+incdir+tests
verilog/cluster_pkg.sv
verilog/dma_req_spill.sv
verilog/dma_beat_counter.sv
verilog/dma_backend_fsm.sv
verilog/cluster_status_regs.sv
verilog/mempool_cluster.sv
tests/tb_mempool_cluster.sv

/* tests/cluster_model.svh */
/*
  Reference model for the cluster testbench, included inside the testbench module.
  Expected beats are queued per group in acceptance order, addresses wrap at 16 bits.
*/

`ifndef CLUSTER_MODEL_SVH
`define CLUSTER_MODEL_SVH

// expected beat addresses per group
cluster_pkg::dma_addr_t exp_beats [cluster_pkg::NumGroups][$];
// requests seen crossing valid/ready
int unsigned accepted_cnt [cluster_pkg::NumGroups];
// done pulses and beats observed at the outputs
int unsigned done_cnt [cluster_pkg::NumGroups];
int unsigned beat_cnt [cluster_pkg::NumGroups];
int unsigned check_cnt;
int unsigned error_cnt;

// one check, mismatch printed on the spot
task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
  check_cnt++;
  if (got !== want) begin
    error_cnt++;
    $display("[FAIL] time %0t signal %s got %0h expected %0h", $time, name, got, want);
  end
endtask

// len beats at start, start+1 and onward
function automatic void record_request(input int g, input cluster_pkg::dma_addr_t start,
                                       input cluster_pkg::dma_len_t len);
  for (int i = 0; i < int'(len); i++) begin
    exp_beats[g].push_back(cluster_pkg::dma_addr_t'(start + i));
  end
  accepted_cnt[g]++;
endfunction

// match one observed beat against the head of the group's stream
task automatic check_beat(input int g, input cluster_pkg::dma_addr_t addr);
  cluster_pkg::dma_addr_t want;
  beat_cnt[g]++;
  if (exp_beats[g].size() == 0) begin
    error_cnt++;
    $display("time %0t: group %0d issued a beat at %0h with no transfer pending",
             $time, g, addr);
  end else begin
    want = exp_beats[g].pop_front();
    compare_value($sformatf("beat_addr_o[%0d]", g), 32'(addr), 32'(want));
  end
endtask

// every stream fully seen and every transfer closed by a done pulse
function automatic bit model_drained();
  for (int g = 0; g < cluster_pkg::NumGroups; g++) begin
    if (exp_beats[g].size() != 0 || done_cnt[g] != accepted_cnt[g]) begin
      return 1'b0;
    end
  end
  return 1'b1;
endfunction

`endif

/* tests/tb_mempool_cluster.sv */
/*
  Random DMA traffic on every group, checked against a queue model. Fixed seed.
  Outputs are sampled on the falling edge, inputs change 1 ns after the rising edge.
*/

`timescale 1ns/1ps

module tb_mempool_cluster;

  localparam int NumGroups   = cluster_pkg::NumGroups;
  localparam int WakeBits    = cluster_pkg::NumCores;
  localparam int ReqPerGroup = 10;
  localparam int WaitLimit   = 200;

  logic                                   clk_i;
  logic                                   rst_n_i;
  logic [WakeBits-1:0]                    wake_up_i;
  logic [WakeBits-1:0]                    wake_up_o;
  cluster_pkg::dma_addr_t [NumGroups-1:0] dma_addr_i;
  cluster_pkg::dma_len_t  [NumGroups-1:0] dma_len_i;
  logic [NumGroups-1:0]                   dma_valid_i;
  logic [NumGroups-1:0]                   dma_ready_o;
  logic [NumGroups-1:0]                   dma_idle_o;
  logic [NumGroups-1:0]                   dma_done_o;
  logic [NumGroups-1:0]                   beat_valid_o;
  cluster_pkg::dma_addr_t [NumGroups-1:0] beat_addr_o;
  // request crosses on the coming rising edge
  logic [NumGroups-1:0]                   fired;

  `include "cluster_model.svh"

  mempool_cluster mempool_cluster_inst (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .wake_up_i    (wake_up_i   ),
    .wake_up_o    (wake_up_o   ),
    .dma_addr_i   (dma_addr_i  ),
    .dma_len_i    (dma_len_i   ),
    .dma_valid_i  (dma_valid_i ),
    .dma_ready_o  (dma_ready_o ),
    .dma_idle_o   (dma_idle_o  ),
    .dma_done_o   (dma_done_o  ),
    .beat_valid_o (beat_valid_o),
    .beat_addr_o  (beat_addr_o )
  );

  always #50 clk_i = ~clk_i;

  // monitor samples outputs mid cycle
  always @(negedge clk_i) begin
    for (int g = 0; g < NumGroups; g++) begin
      fired[g] = rst_n_i && dma_valid_i[g] && dma_ready_o[g];
      if (fired[g]) begin
        record_request(g, dma_addr_i[g], dma_len_i[g]);
      end
      if (rst_n_i && beat_valid_o[g]) begin
        check_beat(g, beat_addr_o[g]);
      end
      if (rst_n_i && dma_done_o[g]) begin
        done_cnt[g]++;
      end
    end
  end

  // lengths 1 to 8 at any start address
  task automatic drive_random_request(input int g);
    dma_addr_i[g]  = cluster_pkg::dma_addr_t'($urandom);
    dma_len_i[g]   = cluster_pkg::dma_len_t'($urandom_range(8, 1));
    dma_valid_i[g] = 1'b1;
  endtask

  task automatic check_idle_outputs();
    for (int g = 0; g < NumGroups; g++) begin
      compare_value($sformatf("dma_ready_o[%0d]", g), 32'(dma_ready_o[g]), 32'd1);
      compare_value($sformatf("dma_idle_o[%0d]", g), 32'(dma_idle_o[g]), 32'd1);
      compare_value($sformatf("beat_valid_o[%0d]", g), 32'(beat_valid_o[g]), 32'd0);
      compare_value($sformatf("dma_done_o[%0d]", g), 32'(dma_done_o[g]), 32'd0);
    end
    compare_value("wake_up_o", 32'(wake_up_o), 32'd0);
  endtask

  task automatic wait_accept(input int g);
    int cyc;
    cyc = 0;
    do begin
      @(posedge clk_i);
      #1;
      cyc++;
    end while (!fired[g] && cyc < WaitLimit);
    if (!fired[g]) begin
      error_cnt++;
      $display("timeout: group %0d request not accepted in %0d cycles", g, WaitLimit);
    end
  endtask

  task automatic wait_done(input int g, input int unsigned target);
    int cyc;
    cyc = 0;
    do begin
      @(posedge clk_i);
      #1;
      cyc++;
    end while (done_cnt[g] < target && cyc < WaitLimit);
    if (done_cnt[g] < target) begin
      error_cnt++;
      $display("timeout: group %0d gave no done pulse in %0d cycles", g, WaitLimit);
    end
  endtask

  task automatic finish_test(input string name, input int unsigned errs_before);
    $display("test %s finished with %0d errors", name, error_cnt - errs_before);
  endtask

  initial begin : main
    int unsigned errs_before;
    int unsigned beats_before;
    int unsigned len_sent;
    int unsigned sent [NumGroups];
    int unsigned stall_cycles;
    logic [WakeBits-1:0] wake_prev;
    bit all_sent;
    int cyc;

    void'($urandom(50422));
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    wake_up_i   = '0;
    dma_addr_i  = '0;
    dma_len_i   = '0;
    dma_valid_i = '0;
    fired       = '0;

    // four edges in reset and two more after release
    errs_before = error_cnt;
    for (int i = 0; i < 6; i++) begin
      @(posedge clk_i);
      #1;
      if (i == 3) begin
        rst_n_i = 1'b1;
      end
      @(negedge clk_i);
      check_idle_outputs();
    end
    finish_test("reset state", errs_before);

    // one transfer per group, the others stay quiet
    errs_before = error_cnt;
    for (int g = 0; g < NumGroups; g++) begin
      beats_before = beat_cnt[g];
      @(posedge clk_i);
      #1;
      drive_random_request(g);
      len_sent = 32'(dma_len_i[g]);
      wait_accept(g);
      dma_valid_i[g] = 1'b0;
      wait_done(g, accepted_cnt[g]);
      compare_value($sformatf("beat count %0d", g), beat_cnt[g] - beats_before, len_sent);
      for (int h = 0; h < NumGroups; h++) begin
        compare_value($sformatf("dma_done_o[%0d] count", h), done_cnt[h], accepted_cnt[h]);
      end
    end
    finish_test("single transfer", errs_before);

    // random gaps with requests held while ready is low
    errs_before  = error_cnt;
    stall_cycles = 0;
    all_sent     = 1'b0;
    cyc          = 0;
    while (!all_sent && cyc < 3000) begin
      @(posedge clk_i);
      #1;
      cyc++;
      all_sent = 1'b1;
      for (int g = 0; g < NumGroups; g++) begin
        if (dma_valid_i[g] && fired[g]) begin
          dma_valid_i[g] = 1'b0;
          sent[g]++;
        end
        if (dma_valid_i[g] && !dma_ready_o[g]) begin
          stall_cycles++;
        end
        if (!dma_valid_i[g] && sent[g] < ReqPerGroup && $urandom_range(1, 0) == 1) begin
          drive_random_request(g);
        end
        if (sent[g] < ReqPerGroup) begin
          all_sent = 1'b0;
        end
      end
    end
    if (!all_sent) begin
      error_cnt++;
      $display("timeout: random requests were not all accepted in 3000 cycles");
    end
    if (stall_cycles == 0) begin
      error_cnt++;
      $display("back-pressure never occurred, dma_ready_o stayed high");
    end
    finish_test("back-pressure", errs_before);

    // drain, then every accepted request must have completed
    errs_before = error_cnt;
    cyc         = 0;
    do begin
      @(posedge clk_i);
      #1;
      cyc++;
    end while (!(model_drained() && dma_idle_o == '1) && cyc < 1000);
    if (!(model_drained() && dma_idle_o == '1)) begin
      error_cnt++;
      $display("timeout: groups did not drain in 1000 cycles");
    end
    for (int g = 0; g < NumGroups; g++) begin
      compare_value($sformatf("dma_done_o[%0d] count", g), done_cnt[g], accepted_cnt[g]);
      compare_value($sformatf("beats missing %0d", g), exp_beats[g].size(), 32'd0);
      compare_value($sformatf("dma_idle_o[%0d]", g), 32'(dma_idle_o[g]), 32'd1);
    end
    finish_test("completion", errs_before);

    // output shows the vector driven one cycle earlier
    errs_before = error_cnt;
    for (int i = 0; i < 32; i++) begin
      @(posedge clk_i);
      #1;
      wake_prev = wake_up_i;
      wake_up_i = WakeBits'($urandom);
      @(negedge clk_i);
      compare_value("wake_up_o", 32'(wake_up_o), 32'(wake_prev));
    end
    finish_test("wake-up", errs_before);

    $display("checks %0d, errors %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verilog/cluster_pkg.sv */
/*
  Shared widths and types for the cluster DMA and control path.
  Group count must stay NumX*NumY. A DMA length of zero is illegal.
*/

package cluster_pkg;

  // group grid, flattened to a linear index g = NumY*x + y
  localparam int unsigned NumX = 2;
  localparam int unsigned NumY = 2;
  localparam int unsigned NumGroups = NumX * NumY;

  // cores
  localparam int unsigned NumCoresPerGroup = 4;
  localparam int unsigned NumCores = NumGroups * NumCoresPerGroup;

  // dma request fields
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned LenWidth = 8;

  // start word address of a transfer
  typedef logic [AddrWidth-1:0] dma_addr_t;
  // number of word beats, never zero
  typedef logic [LenWidth-1:0] dma_len_t;
  // flat group index
  typedef logic [$clog2(NumGroups)-1:0] group_idx_t;

  // backend states
  typedef enum logic [1:0] {
    DmaIdle = 2'd0,
    DmaBusy = 2'd1,
    DmaDone = 2'd2
  } dma_state_e;

endpackage

/* verilog/cluster_status_regs.sv */
/*
  Control and status registers of the cluster, one cycle behind their inputs.
  Core c of group g sits at wake-up bit g*NumCoresPerGroup + c.
*/

`timescale 1ns/1ps

module cluster_status_regs #(
  parameter int unsigned NumGroups        = 4,
  parameter int unsigned NumCoresPerGroup = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  // wake-up lines, per core
  input  logic [NumGroups*NumCoresPerGroup-1:0] wake_up_i,
  output logic [NumGroups*NumCoresPerGroup-1:0] wake_up_o,
  // raw dma status, per group
  input  logic [NumGroups-1:0]                  idle_i,
  input  logic [NumGroups-1:0]                  done_i,
  output logic [NumGroups-1:0]                  idle_o,
  output logic [NumGroups-1:0]                  done_o
);

  logic [NumGroups*NumCoresPerGroup-1:0] wake_up_q;
  logic [NumGroups-1:0]                  idle_q;
  logic [NumGroups-1:0]                  done_q;

  // wake-up vector, cores asleep out of reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wake_up_q <= '0;
    end else begin
      wake_up_q <= wake_up_i;
    end
  end

  // dma status
  // backends come out of reset idle with nothing done
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      idle_q <= '1;
      done_q <= '0;
    end else begin
      idle_q <= idle_i;
      done_q <= done_i;
    end
  end

  assign wake_up_o = wake_up_q;
  assign idle_o    = idle_q;
  assign done_o    = done_q;

endmodule

/* verilog/dma_backend_fsm.sv */
/*
  Per-group DMA backend, one addressed word beat per cycle after accept.
  Accepts only in DmaIdle. Addresses wrap at AddrWidth without warning.
*/

`timescale 1ns/1ps

module dma_backend_fsm (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // request from the spill register
  input  cluster_pkg::dma_addr_t req_addr_i,
  input  cluster_pkg::dma_len_t  req_len_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  // beat stream
  output logic                   beat_valid_o,
  output cluster_pkg::dma_addr_t beat_addr_o,
  // raw status levels
  output logic                   idle_o,
  output logic                   done_o
);

  cluster_pkg::dma_state_e state_q;
  cluster_pkg::dma_state_e state_d;
  // start address of the running transfer
  cluster_pkg::dma_addr_t  base_q;
  cluster_pkg::dma_len_t   beat_idx;
  logic                    last;
  logic                    load;
  logic                    step;

  assign req_ready_o  = (state_q == cluster_pkg::DmaIdle);
  assign load         = req_valid_i && req_ready_o;
  assign beat_valid_o = (state_q == cluster_pkg::DmaBusy);
  assign step         = beat_valid_o;
  assign idle_o       = (state_q == cluster_pkg::DmaIdle);
  assign done_o       = (state_q == cluster_pkg::DmaDone);
  // index is zero extended onto the word address
  assign beat_addr_o  = base_q + cluster_pkg::dma_addr_t'(beat_idx);

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      cluster_pkg::DmaIdle: begin
        if (load) begin
          state_d = cluster_pkg::DmaBusy;
        end
      end
      cluster_pkg::DmaBusy: begin
        // leave after the beat flagged last
        if (last) begin
          state_d = cluster_pkg::DmaDone;
        end
      end
      cluster_pkg::DmaDone: begin
        state_d = cluster_pkg::DmaIdle;
      end
      default: begin
        state_d = cluster_pkg::DmaIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= cluster_pkg::DmaIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // base address latched on accept
  always_ff @(posedge clk_i) begin
    if (load) begin
      base_q <= req_addr_i;
    end
  end

  dma_beat_counter i_beat_counter (
    .clk_i   (clk_i    ),
    .rst_n_i (rst_n_i  ),
    .load_i  (load     ),
    .len_i   (req_len_i),
    .step_i  (step     ),
    .idx_o   (beat_idx ),
    .last_o  (last     )
  );

  // a zero length would never raise last and hang the group
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    load |-> req_len_i != '0)
    else $error("dma request accepted with zero length");

  // beats only inside a busy period opened by an accept
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    beat_valid_o |-> $past(load) || $past(beat_valid_o && !last))
    else $error("dma beat outside of busy state");

  // the final beat is followed by exactly one done cycle
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    beat_valid_o && last |=> done_o ##1 idle_o)
    else $error("dma transfer did not end with a done cycle");

endmodule

/* verilog/dma_beat_counter.sv */
/*
  Beat counter for one DMA transfer. load_i wins over step_i.
  last_o is meaningful only while a transfer is running.
*/

`timescale 1ns/1ps

module dma_beat_counter (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  load_i,
  input  cluster_pkg::dma_len_t len_i,
  input  logic                  step_i,
  output cluster_pkg::dma_len_t idx_o,
  output logic                  last_o
);

  // beats still to issue, counting the current one
  cluster_pkg::dma_len_t remain_q;
  // index of the current beat
  cluster_pkg::dma_len_t idx_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      remain_q <= '0;
      idx_q    <= '0;
    end else if (load_i) begin
      remain_q <= len_i;
      idx_q    <= '0;
    end else if (step_i) begin
      remain_q <= remain_q - 1'b1;
      idx_q    <= idx_q + 1'b1;
    end
  end

  assign idx_o = idx_q;
  // one beat left
  assign last_o = (remain_q == cluster_pkg::dma_len_t'(1));

endmodule

/* verilog/dma_req_spill.sv */
/*
  Two-entry spill register on a valid/ready DMA request, first in first out.
  ready_o depends on registered state only and drops when both slots hold data.
*/

`timescale 1ns/1ps

module dma_req_spill (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // upstream side
  input  cluster_pkg::dma_addr_t addr_i,
  input  cluster_pkg::dma_len_t  len_i,
  input  logic                   valid_i,
  output logic                   ready_o,
  // downstream side
  output cluster_pkg::dma_addr_t addr_o,
  output cluster_pkg::dma_len_t  len_o,
  output logic                   valid_o,
  input  logic                   ready_i
);

  // slot a feeds the output, slot b catches while a is stalled
  logic                   a_full_q;
  logic                   b_full_q;
  cluster_pkg::dma_addr_t a_addr_q;
  cluster_pkg::dma_addr_t b_addr_q;
  cluster_pkg::dma_len_t  a_len_q;
  cluster_pkg::dma_len_t  b_len_q;
  logic                   in_fire;
  logic                   out_fire;
  logic                   a_free;

  assign ready_o  = !b_full_q;
  assign valid_o  = a_full_q;
  assign addr_o   = a_addr_q;
  assign len_o    = a_len_q;
  assign in_fire  = valid_i && ready_o;
  assign out_fire = a_full_q && ready_i;
  // a can be written this cycle
  assign a_free   = !a_full_q || out_fire;

  // occupancy flags
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else if (a_free) begin
      // b drains into a first, otherwise a takes the new request
      a_full_q <= b_full_q || in_fire;
      b_full_q <= 1'b0;
    end else if (in_fire) begin
      b_full_q <= 1'b1;
    end
  end

  // payload registers
  always_ff @(posedge clk_i) begin
    if (a_free) begin
      if (b_full_q) begin
        a_addr_q <= b_addr_q;
        a_len_q  <= b_len_q;
      end else if (in_fire) begin
        a_addr_q <= addr_i;
        a_len_q  <= len_i;
      end
    end
    if (!a_free && in_fire) begin
      b_addr_q <= addr_i;
      b_len_q  <= len_i;
    end
  end

  // a stalled request must hold until the backend takes it
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(addr_o) && $stable(len_o))
    else $error("dma spill output changed while stalled");

endmodule

/* verilog/mempool_cluster.sv */
/*
  Cluster wrapper keeping only the DMA and control path of each group.
  Groups are addressed by flat index. Request fields must hold until ready.
*/

`timescale 1ns/1ps

module mempool_cluster #(
  parameter int unsigned NumGroups        = cluster_pkg::NumGroups,
  parameter int unsigned NumCoresPerGroup = cluster_pkg::NumCoresPerGroup
) (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  // wake-up lines
  input  logic [NumGroups*NumCoresPerGroup-1:0]        wake_up_i,
  output logic [NumGroups*NumCoresPerGroup-1:0]        wake_up_o,
  // dma requests, one port per group
  input  cluster_pkg::dma_addr_t [NumGroups-1:0]       dma_addr_i,
  input  cluster_pkg::dma_len_t  [NumGroups-1:0]       dma_len_i,
  input  logic                   [NumGroups-1:0]       dma_valid_i,
  output logic                   [NumGroups-1:0]       dma_ready_o,
  // dma status
  output logic                   [NumGroups-1:0]       dma_idle_o,
  output logic                   [NumGroups-1:0]       dma_done_o,
  // beat streams
  output logic                   [NumGroups-1:0]       beat_valid_o,
  output cluster_pkg::dma_addr_t [NumGroups-1:0]       beat_addr_o
);

  // spill to backend
  cluster_pkg::dma_addr_t [NumGroups-1:0] req_addr;
  cluster_pkg::dma_len_t  [NumGroups-1:0] req_len;
  logic                   [NumGroups-1:0] req_valid;
  logic                   [NumGroups-1:0] req_ready;
  // raw status before the register file
  logic                   [NumGroups-1:0] idle_raw;
  logic                   [NumGroups-1:0] done_raw;

  for (genvar g = 0; g < NumGroups; g++) begin : gen_groups
    dma_req_spill i_dma_req_spill (
      .clk_i   (clk_i         ),
      .rst_n_i (rst_n_i       ),
      .addr_i  (dma_addr_i[g] ),
      .len_i   (dma_len_i[g]  ),
      .valid_i (dma_valid_i[g]),
      .ready_o (dma_ready_o[g]),
      .addr_o  (req_addr[g]   ),
      .len_o   (req_len[g]    ),
      .valid_o (req_valid[g]  ),
      .ready_i (req_ready[g]  )
    );

    dma_backend_fsm i_dma_backend (
      .clk_i        (clk_i          ),
      .rst_n_i      (rst_n_i        ),
      .req_addr_i   (req_addr[g]    ),
      .req_len_i    (req_len[g]     ),
      .req_valid_i  (req_valid[g]   ),
      .req_ready_o  (req_ready[g]   ),
      .beat_valid_o (beat_valid_o[g]),
      .beat_addr_o  (beat_addr_o[g] ),
      .idle_o       (idle_raw[g]    ),
      .done_o       (done_raw[g]    )
    );
  end : gen_groups

  // one register file for the whole cluster
  cluster_status_regs #(
    .NumGroups        (NumGroups       ),
    .NumCoresPerGroup (NumCoresPerGroup)
  ) i_status_regs (
    .clk_i     (clk_i     ),
    .rst_n_i   (rst_n_i   ),
    .wake_up_i (wake_up_i ),
    .wake_up_o (wake_up_o ),
    .idle_i    (idle_raw  ),
    .done_i    (done_raw  ),
    .idle_o    (dma_idle_o),
    .done_o    (dma_done_o)
  );

endmodule
